// File: rtl/debug_consts.svh
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// pipeline slots reported by the cpu
`define DBG_NUM_STAGES 7

// pc and opcode width per slot
`define DBG_PC_W 7

// widest value shown in decimal
`define DBG_VALUE_W 20

// seven-segment digits on the board
`define DBG_NUM_DIGITS 6

// leds and slide switches
`define DBG_LED_W 10

`endif

// File: rtl/debug_pkg.sv
`default_nettype none

package debug_pkg;

  // one decimal digit, 0 to 9
  typedef logic [3:0] digit_t;

  // active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // what the switches ask to show
  typedef enum logic [1:0] {
    pc_mode   = 2'd0,
    reg_mode  = 2'd1,
    flag_mode = 2'd2
  } disp_mode_e;

  // digit position, 0 is the rightmost display
  typedef logic [2:0] digit_idx_t;

endpackage

`default_nettype wire

// File: rtl/probe_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

interface probe_if;
  import debug_pkg::*;

  // one-cycle capture request
  logic                    start;
  // held from start until the next start
  logic [`DBG_VALUE_W-1:0] value;
  disp_mode_e              mode;
  logic                    display_on;

  modport src (output start, output value, output mode, output display_on);
  modport dst (input start, input value, input mode, input display_on);

endinterface

`default_nettype wire

// File: rtl/digit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface digit_if;
  import debug_pkg::*;

  // blank all displays, one cycle
  logic       clear;
  // one strobe per digit, index rising
  logic       valid;
  digit_idx_t index;
  digit_t     digit;
  logic       display_on;

  modport src (output clear, output valid, output index, output digit, output display_on);
  modport dst (input clear, input valid, input index, input digit, input display_on);

endinterface

`default_nettype wire

// File: rtl/probe_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module probe_select (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire [`DBG_PC_W-1:0]   pc_stage [`DBG_NUM_STAGES],
  input  wire [`DBG_PC_W-1:0]   opcode_stage [`DBG_NUM_STAGES],
  input  wire [31:0]            selected_register,
  input  wire [31:0]            status_register,
  input  wire [`DBG_LED_W-1:0]  sw,
  probe_if.src                  probe,
  output logic [`DBG_LED_W-1:0] ledr
);
  import debug_pkg::*;

  // sw[7:3] code that selects the status flags
  localparam logic [4:0] FLAG_SEL = 5'b10000;

  logic [`DBG_LED_W-1:0]   sw_q;
  logic [`DBG_LED_W-1:0]   sw_prev;
  logic                    init_q;
  logic                    arm_q;
  logic                    start_next;
  logic [2:0]              slot;
  logic [`DBG_PC_W-1:0]    slot_pc;
  logic [`DBG_PC_W-1:0]    slot_opcode;
  logic [`DBG_PC_W-1:0]    opcode_rev;
  disp_mode_e              mode_next;
  logic [`DBG_VALUE_W-1:0] value_next;
  logic [`DBG_LED_W-1:0]   led_next;
  logic [`DBG_LED_W-1:0]   led_q;

  assign slot = sw_q[2:0];

  // slot mux, code 7 reads as zero
  always_comb begin
    slot_pc     = '0;
    slot_opcode = '0;
    if (int'(slot) < `DBG_NUM_STAGES) begin
      slot_pc     = pc_stage[slot];
      slot_opcode = opcode_stage[slot];
    end
  end

  // ledr[0] carries opcode bit 6
  always_comb begin
    for (int i = 0; i < `DBG_PC_W; i++) begin
      opcode_rev[i] = slot_opcode[`DBG_PC_W-1-i];
    end
  end

  // flag select wins over register select
  always_comb begin
    value_next = '0;
    if (sw_q[7:3] == FLAG_SEL) begin
      mode_next       = flag_mode;
      value_next[3:0] = status_register[31:28];
    end else if (sw_q[8]) begin
      mode_next  = reg_mode;
      value_next = selected_register[`DBG_VALUE_W-1:0];
    end else begin
      mode_next                   = pc_mode;
      value_next[`DBG_PC_W-1:0]   = slot_pc;
    end
  end

  always_comb begin
    led_next = '0;
    if (sw_q[8]) begin
      led_next = '1;
    end else begin
      led_next[`DBG_PC_W-1:0] = opcode_rev;
    end
  end

  // arm_q gives the single capture after reset
  assign start_next = (sw_q != sw_prev) || arm_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_q        <= '0;
      sw_prev     <= '0;
      init_q      <= 1'b1;
      arm_q       <= 1'b0;
      probe.start <= 1'b0;
      led_q       <= '1;
    end else begin
      sw_q        <= sw;
      sw_prev     <= sw_q;
      init_q      <= 1'b0;
      arm_q       <= init_q;
      probe.start <= start_next;
      if (!init_q) begin
        led_q <= led_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_next) begin
      probe.value <= value_next;
      probe.mode  <= mode_next;
    end
  end

  assign probe.display_on = sw_q[9];
  assign ledr             = sw_q[9] ? led_q : '1;

endmodule

`default_nettype wire

// File: rtl/digit_extractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module digit_extractor (
  input  wire  clk,
  input  wire  rst_n,
  probe_if.dst probe,
  digit_if.src digits
);
  import debug_pkg::*;

  localparam digit_idx_t LAST_IDX = digit_idx_t'(`DBG_NUM_DIGITS - 1);

  logic [`DBG_VALUE_W-1:0] work;
  logic [`DBG_VALUE_W-1:0] work_next;
  digit_t                  digit_next;
  disp_mode_e              mode_q;
  digit_idx_t              cnt;
  logic                    busy;

  // one base ten step, or one flag bit per digit
  always_comb begin
    if (mode_q == flag_mode) begin
      digit_next = {3'b000, work[0]};
      work_next  = work >> 1;
    end else begin
      digit_next = digit_t'(work % `DBG_VALUE_W'(10));
      work_next  = work / `DBG_VALUE_W'(10);
    end
  end

  // a new start always restarts the sequence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      cnt          <= '0;
      digits.clear <= 1'b0;
      digits.valid <= 1'b0;
    end else begin
      digits.clear <= probe.start;
      digits.valid <= 1'b0;
      if (probe.start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        digits.valid <= 1'b1;
        cnt          <= cnt + 1'b1;
        if (cnt == LAST_IDX) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (probe.start) begin
      work   <= probe.value;
      mode_q <= probe.mode;
    end else if (busy) begin
      work         <= work_next;
      digits.index <= cnt;
      digits.digit <= digit_next;
    end
  end

  assign digits.display_on = probe.display_on;

endmodule

`default_nettype wire

// File: rtl/seg_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module seg_encoder (
  input  wire             clk,
  input  wire             rst_n,
  digit_if.dst            digits,
  output debug_pkg::seg_t hex0,
  output debug_pkg::seg_t hex1,
  output debug_pkg::seg_t hex2,
  output debug_pkg::seg_t hex3,
  output debug_pkg::seg_t hex4,
  output debug_pkg::seg_t hex5
);
  import debug_pkg::*;

  seg_t seg_q [`DBG_NUM_DIGITS];

  // active low patterns, gfedcba
  function automatic seg_t seg_lookup(input digit_t d);
    case (d)
      4'd0:    seg_lookup = 7'b1000000;
      4'd1:    seg_lookup = 7'b1111001;
      4'd2:    seg_lookup = 7'b0100100;
      4'd3:    seg_lookup = 7'b0110000;
      4'd4:    seg_lookup = 7'b0011001;
      4'd5:    seg_lookup = 7'b0010010;
      4'd6:    seg_lookup = 7'b0000010;
      4'd7:    seg_lookup = 7'b1111000;
      4'd8:    seg_lookup = 7'b0000000;
      4'd9:    seg_lookup = 7'b0010000;
      default: seg_lookup = 7'b1111111;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `DBG_NUM_DIGITS; i++) begin
        seg_q[i] <= '1;
      end
    end else if (digits.clear) begin
      for (int i = 0; i < `DBG_NUM_DIGITS; i++) begin
        seg_q[i] <= '1;
      end
    end else if (digits.valid && (int'(digits.index) < `DBG_NUM_DIGITS)) begin
      seg_q[digits.index] <= seg_lookup(digits.digit);
    end
  end

  // dark board while the display switch is off
  assign hex0 = digits.display_on ? seg_q[0] : '1;
  assign hex1 = digits.display_on ? seg_q[1] : '1;
  assign hex2 = digits.display_on ? seg_q[2] : '1;
  assign hex3 = digits.display_on ? seg_q[3] : '1;
  assign hex4 = digits.display_on ? seg_q[4] : '1;
  assign hex5 = digits.display_on ? seg_q[5] : '1;

endmodule

`default_nettype wire

// File: rtl/cpu_debug_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module cpu_debug_display (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire [`DBG_PC_W-1:0]   pc_stage [`DBG_NUM_STAGES],
  input  wire [`DBG_PC_W-1:0]   opcode_stage [`DBG_NUM_STAGES],
  input  wire [31:0]            selected_register,
  input  wire [31:0]            status_register,
  input  wire [`DBG_LED_W-1:0]  sw,
  output debug_pkg::seg_t       hex0,
  output debug_pkg::seg_t       hex1,
  output debug_pkg::seg_t       hex2,
  output debug_pkg::seg_t       hex3,
  output debug_pkg::seg_t       hex4,
  output debug_pkg::seg_t       hex5,
  output logic [`DBG_LED_W-1:0] ledr
);

  // capture request, probe stage to digit stage
  probe_if i_probe_if ();

  // digit stream, digit stage to segment stage
  digit_if i_digit_if ();

  probe_select i_probe_select (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_stage          (pc_stage),
    .opcode_stage      (opcode_stage),
    .selected_register (selected_register),
    .status_register   (status_register),
    .sw                (sw),
    .probe             (i_probe_if.src),
    .ledr              (ledr)
  );

  digit_extractor i_digit_extractor (
    .clk    (clk),
    .rst_n  (rst_n),
    .probe  (i_probe_if.dst),
    .digits (i_digit_if.src)
  );

  seg_encoder i_seg_encoder (
    .clk    (clk),
    .rst_n  (rst_n),
    .digits (i_digit_if.dst),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

endmodule

`default_nettype wire

// File: dv/tb_cpu_debug_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_consts.svh"

module tb_cpu_debug_display;
  import debug_pkg::*;

  localparam int MAX_VECTORS       = 64;
  localparam int VEC_W             = 128;
  localparam int CYCLES_PER_VECTOR = 16;
  localparam int SETTLE_CYCLES     = 12;
  localparam int HOLD_CYCLES       = 2;

  logic                  clk;
  logic                  rst_n;
  logic [`DBG_PC_W-1:0]  pc_stage [`DBG_NUM_STAGES];
  logic [`DBG_PC_W-1:0]  opcode_stage [`DBG_NUM_STAGES];
  logic [31:0]           selected_register;
  logic [31:0]           status_register;
  logic [`DBG_LED_W-1:0] sw;
  seg_t                  hex0;
  seg_t                  hex1;
  seg_t                  hex2;
  seg_t                  hex3;
  seg_t                  hex4;
  seg_t                  hex5;
  logic [`DBG_LED_W-1:0] ledr;

  logic [VEC_W-1:0] vec_mem [MAX_VECTORS];
  int               num_vectors;
  int               cycle_cnt = 0;
  int               timeout_limit = 1000000;
  logic [31:0]      lfsr_state;

  cpu_debug_display i_cpu_debug_display (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_stage          (pc_stage),
    .opcode_stage      (opcode_stage),
    .selected_register (selected_register),
    .status_register   (status_register),
    .sw                (sw),
    .hex0              (hex0),
    .hex1              (hex1),
    .hex2              (hex2),
    .hex3              (hex3),
    .hex4              (hex4),
    .hex5              (hex5),
    .ledr              (ledr)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped by timeout");
    end
  end

  // board segment patterns, active low, bit 0 is segment a
  function automatic seg_t expected_seg(input digit_t d);
    seg_t s;
    case (d)
      4'd0:    s = 7'h40;
      4'd1:    s = 7'h79;
      4'd2:    s = 7'h24;
      4'd3:    s = 7'h30;
      4'd4:    s = 7'h19;
      4'd5:    s = 7'h12;
      4'd6:    s = 7'h02;
      4'd7:    s = 7'h78;
      4'd8:    s = 7'h00;
      4'd9:    s = 7'h10;
      default: s = 7'h7f;
    endcase
    return s;
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_seg(input string name, input seg_t got, input seg_t expected);
    if (got !== expected) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "segment mismatch");
    end
  endtask

  task automatic check_led(input string name, input logic [`DBG_LED_W-1:0] got,
                           input logic [`DBG_LED_W-1:0] expected);
    if (got !== expected) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "led mismatch");
    end
  endtask

  // nibbles ordered hex5 down to hex0
  task automatic check_display(input logic [23:0] digits);
    check_seg("hex0", hex0, expected_seg(digits[3:0]));
    check_seg("hex1", hex1, expected_seg(digits[7:4]));
    check_seg("hex2", hex2, expected_seg(digits[11:8]));
    check_seg("hex3", hex3, expected_seg(digits[15:12]));
    check_seg("hex4", hex4, expected_seg(digits[19:16]));
    check_seg("hex5", hex5, expected_seg(digits[23:20]));
  endtask

  // slot s gets base + s, wrapping at 128
  task automatic apply_vector(input logic [VEC_W-1:0] v);
    logic [7:0] pc_base;
    logic [7:0] op_base;
    pc_base           = v[115:108];
    op_base           = v[107:100];
    sw                = v[125:116];
    selected_register = v[99:68];
    status_register   = v[67:36];
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      pc_stage[s]     = `DBG_PC_W'(pc_base + 8'(s));
      opcode_stage[s] = `DBG_PC_W'(op_base + 8'(s));
    end
  endtask

  // one lfsr step per bit
  task automatic scramble_probes();
    logic [`DBG_PC_W-1:0] pc_bits;
    logic [`DBG_PC_W-1:0] op_bits;
    logic [31:0]          reg_bits;
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      for (int b = 0; b < `DBG_PC_W; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        pc_bits[b] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        op_bits[b] = lfsr_state[0];
      end
      pc_stage[s]     = pc_bits;
      opcode_stage[s] = op_bits;
    end
    for (int b = 0; b < 32; b++) begin
      lfsr_state  = lfsr_next(lfsr_state);
      reg_bits[b] = lfsr_state[0];
    end
    selected_register = reg_bits;
  endtask

  initial begin
    logic [VEC_W-1:0] vec;
    rst_n             = 1'b0;
    sw                = '0;
    selected_register = '0;
    status_register   = '0;
    for (int s = 0; s < `DBG_NUM_STAGES; s++) begin
      pc_stage[s]     = '0;
      opcode_stage[s] = '0;
    end
    lfsr_state = 32'h3ee1;

    // all ones marks an unused entry
    for (int i = 0; i < MAX_VECTORS; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("dv/display_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vec_mem[num_vectors] != '1) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("No test vectors were read from dv/display_vectors.txt");
      $display("*** TEST FAILED ***");
      $fatal(1, "empty vector file");
    end
    timeout_limit = num_vectors * CYCLES_PER_VECTOR + 50;

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < num_vectors; n++) begin
      vec = vec_mem[n];
      @(posedge clk);
      #1;
      apply_vector(vec);
      repeat (SETTLE_CYCLES) @(posedge clk);
      @(negedge clk);
      check_display(vec[35:12]);
      check_led("ledr", ledr, vec[`DBG_LED_W-1:0]);

      // captured value must survive new cpu inputs
      @(posedge clk);
      #1;
      scramble_probes();
      repeat (HOLD_CYCLES) @(posedge clk);
      @(negedge clk);
      check_display(vec[35:12]);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/debug_pkg.sv
rtl/probe_if.sv
rtl/digit_if.sv
rtl/probe_select.sv
rtl/digit_extractor.sv
rtl/seg_encoder.sv
rtl/cpu_debug_display.sv
dv/tb_cpu_debug_display.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_cpu_debug_display
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) dv/display_vectors.txt
	-./$(SIM_BIN) 2>&1 | tee $(SIM_LOG)

check: run
	@if grep -qF "*** TEST FAILED ***" $(SIM_LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(SIM_LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: dv/display_vectors.txt
// sw _ pc_base _ opcode_base _ selected_register _ status_register _ hex5..hex0 _ ledr
// digit nibble f means a blank display
200_7c_40_00000000_00000000_000124_001
201_7c_40_00000000_00000000_000125_041
202_7c_40_00000000_00000000_000126_021
203_7c_40_00000000_00000000_000127_061
204_7c_40_00000000_00000000_000000_011
205_7c_40_00000000_00000000_000001_051
206_7c_40_00000000_00000000_000002_031
207_7c_40_00000000_00000000_000000_000
203_31_15_00000000_00000000_000052_00c
206_31_15_00000000_00000000_000055_06c
300_10_20_000f423f_00000000_999999_3ff
301_10_20_000f4240_00000000_000000_3ff
302_10_20_ffffffff_00000000_048575_3ff
303_10_20_12345678_00000000_284280_3ff
307_10_20_0000002a_00000000_000042_3ff
304_10_20_abc01e61_00000000_007777_3ff
280_10_20_00000000_a0000000_001010_002
285_10_20_00000000_5fffffff_000101_052
380_10_20_0000ffff_f0000000_001111_3ff
287_10_20_00000000_10000000_000001_000
005_10_20_00000000_00000000_ffffff_3ff
105_10_20_00001234_00000000_ffffff_3ff
205_10_20_00000000_00000000_000021_052
304_10_20_0001869f_00000000_099999_3ff
2c2_10_20_00000000_f0000000_000018_022
